/* logic/adma_config.svh */
`ifndef ADMA_CONFIG_SVH
`define ADMA_CONFIG_SVH

////////////////////////////////////////////////////////////
// Bus and descriptor widths
////////////////////////////////////////////////////////////

// System address
`define ADMA_ADDR_W 32

// Data word on memory and card side
`define ADMA_DATA_W 32

// Word count field of a descriptor
`define ADMA_LEN_W 16

////////////////////////////////////////////////////////////
// Address steps in bytes
////////////////////////////////////////////////////////////

`define ADMA_DESC_STRIDE 8
`define ADMA_WORD_BYTES 4

`endif

/* logic/adma_pkg.sv */
`include "adma_config.svh"

package adma_pkg;

  ////////////////////////////////////////////////////////////
  // Plain vectors
  ////////////////////////////////////////////////////////////

  typedef logic [`ADMA_ADDR_W-1:0] addr_t;
  typedef logic [`ADMA_DATA_W-1:0] word_t;
  typedef logic [`ADMA_LEN_W-1:0]  len_t;

  // ADMA2 action field, attribute bits 5:4
  typedef enum logic [1:0] {
    act_nop  = 2'b00,
    act_rsv  = 2'b01,
    act_tran = 2'b10,
    act_link = 2'b11
  } adma_act_t;

  // One 64-bit descriptor line, attribute word in the low half
  typedef struct packed {
    addr_t     address;
    len_t      length;
    logic [9:0] attr_rsvd;
    adma_act_t act;
    logic [1:0] attr_misc;
    logic      end_bit;
    logic      valid;
  } adma_desc_t;

  // Single-word memory request
  typedef struct packed {
    addr_t addr;
    logic  write;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic xfer_done;
    logic adma_error;
  } dma_irq_t;

  // Descriptor walk
  typedef enum logic [1:0] {
    st_stop,
    st_fds,
    st_cadr,
    st_tfr
  } seq_state_t;

endpackage

/* logic/adma_sequencer.sv */
`timescale 1ns/1ps
`include "adma_config.svh"

module adma_sequencer (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 start,
  input  adma_pkg::addr_t      table_addr,
  input  logic                 irq_clear,
  output adma_pkg::dma_irq_t   irq,
  output logic                 busy,
  output logic                 fetch_start,
  output logic                 prefetch_start,
  output adma_pkg::addr_t      fetch_addr,
  input  logic                 fetch_done,
  input  adma_pkg::adma_desc_t fetch_desc,
  output logic                 move_start,
  output adma_pkg::adma_desc_t move_desc,
  input  logic                 move_done
);
  import adma_pkg::*;

  seq_state_t state;
  addr_t      table_ptr;
  addr_t      next_ptr;
  adma_desc_t desc;

  // Next sequential descriptor line
  assign next_ptr  = table_ptr + addr_t'(`ADMA_DESC_STRIDE);
  assign busy      = (state != st_stop);
  assign move_desc = desc;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state          <= st_stop;
      irq            <= '0;
      fetch_start    <= 1'b0;
      prefetch_start <= 1'b0;
      move_start     <= 1'b0;
    end else begin
      fetch_start    <= 1'b0;
      prefetch_start <= 1'b0;
      move_start     <= 1'b0;

      // A new event in the same cycle wins over the clear
      if (irq_clear) begin
        irq <= '0;
      end

      case (state)
        st_stop: begin
          if (start) begin
            table_ptr   <= table_addr;
            fetch_addr  <= table_addr;
            fetch_start <= 1'b1;
            state       <= st_fds;
          end
        end

        st_fds: begin
          if (fetch_done) begin
            desc <= fetch_desc;
            if (fetch_desc.valid) begin
              state <= st_cadr;
            end else begin
              irq.adma_error <= 1'b1;
              state          <= st_stop;
            end
          end
        end

        st_cadr: begin
          case (desc.act)
            act_tran: begin
              move_start <= 1'b1;
              state      <= st_tfr;
              // Next line is read while the data moves
              if (!desc.end_bit) begin
                prefetch_start <= 1'b1;
                fetch_addr     <= next_ptr;
              end
            end
            act_link: begin
              table_ptr <= desc.address;
              if (desc.end_bit) begin
                irq.xfer_done <= 1'b1;
                state         <= st_stop;
              end else begin
                fetch_start <= 1'b1;
                fetch_addr  <= desc.address;
                state       <= st_fds;
              end
            end
            // Nop and reserved only step the pointer
            default: begin
              table_ptr <= next_ptr;
              if (desc.end_bit) begin
                irq.xfer_done <= 1'b1;
                state         <= st_stop;
              end else begin
                fetch_start <= 1'b1;
                fetch_addr  <= next_ptr;
                state       <= st_fds;
              end
            end
          endcase
        end

        st_tfr: begin
          if (move_done) begin
            if (desc.end_bit) begin
              irq.xfer_done <= 1'b1;
              state         <= st_stop;
            end else begin
              table_ptr   <= next_ptr;
              fetch_start <= 1'b1;
              fetch_addr  <= next_ptr;
              state       <= st_fds;
            end
          end
        end

        default: state <= st_stop;
      endcase
    end
  end

endmodule

/* logic/adma_desc_fetch.sv */
`timescale 1ns/1ps
`include "adma_config.svh"

module adma_desc_fetch (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 fetch_start,
  input  logic                 prefetch_start,
  input  adma_pkg::addr_t      fetch_addr,
  output logic                 fetch_done,
  output adma_pkg::adma_desc_t fetch_desc,
  output adma_pkg::mem_req_t   mem_req,
  output logic                 mem_req_valid,
  input  logic                 mem_req_ready,
  input  logic                 mem_rsp_valid,
  input  adma_pkg::word_t      mem_rsp_data
);
  import adma_pkg::*;

  // Two-word read in progress
  logic  active;
  logic  wait_rsp;
  logic  second;
  logic  for_prefetch;
  addr_t cur_addr;
  word_t attr_word;

  // Prefetched line and its address
  logic       buf_valid;
  addr_t      buf_tag;
  adma_desc_t buf_desc;

  // Demand fetch that arrived during a prefetch
  logic  pend;
  addr_t pend_addr;

  logic       want;
  addr_t      want_addr;
  logic       hit;
  adma_desc_t rsp_desc;

  assign want      = fetch_start | pend;
  assign want_addr = fetch_start ? fetch_addr : pend_addr;
  assign hit       = buf_valid && (buf_tag == want_addr);
  assign rsp_desc  = adma_desc_t'({mem_rsp_data, attr_word});

  always_ff @(posedge clock) begin
    if (!reset) begin
      active        <= 1'b0;
      wait_rsp      <= 1'b0;
      second        <= 1'b0;
      for_prefetch  <= 1'b0;
      mem_req_valid <= 1'b0;
      fetch_done    <= 1'b0;
      buf_valid     <= 1'b0;
      pend          <= 1'b0;
    end else begin
      fetch_done <= 1'b0;

      if (active) begin
        if (fetch_start) begin
          pend      <= 1'b1;
          pend_addr <= fetch_addr;
        end
        if (mem_req_valid && mem_req_ready) begin
          mem_req_valid <= 1'b0;
          wait_rsp      <= 1'b1;
        end
        if (wait_rsp && mem_rsp_valid) begin
          wait_rsp <= 1'b0;
          if (!second) begin
            // Attribute word in, now the address word
            attr_word     <= mem_rsp_data;
            second        <= 1'b1;
            mem_req_valid <= 1'b1;
            mem_req       <= '{addr: cur_addr + addr_t'(`ADMA_WORD_BYTES),
                               write: 1'b0, wdata: '0};
          end else if (for_prefetch) begin
            active    <= 1'b0;
            buf_valid <= 1'b1;
            buf_tag   <= cur_addr;
            buf_desc  <= rsp_desc;
          end else begin
            active     <= 1'b0;
            fetch_done <= 1'b1;
            fetch_desc <= rsp_desc;
          end
        end
      end else if (want) begin
        // The buffer serves at most one request
        pend      <= 1'b0;
        buf_valid <= 1'b0;
        if (hit) begin
          fetch_done <= 1'b1;
          fetch_desc <= buf_desc;
        end else begin
          active        <= 1'b1;
          second        <= 1'b0;
          for_prefetch  <= 1'b0;
          cur_addr      <= want_addr;
          mem_req_valid <= 1'b1;
          mem_req       <= '{addr: want_addr, write: 1'b0, wdata: '0};
        end
      end else if (prefetch_start) begin
        active        <= 1'b1;
        second        <= 1'b0;
        for_prefetch  <= 1'b1;
        buf_valid     <= 1'b0;
        cur_addr      <= fetch_addr;
        mem_req_valid <= 1'b1;
        mem_req       <= '{addr: fetch_addr, write: 1'b0, wdata: '0};
      end
    end
  end

endmodule

/* logic/adma_data_mover.sv */
`timescale 1ns/1ps
`include "adma_config.svh"

module adma_data_mover (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 to_card,
  input  logic                 move_start,
  input  adma_pkg::adma_desc_t move_desc,
  output logic                 move_done,
  output adma_pkg::mem_req_t   mem_req,
  output logic                 mem_req_valid,
  input  logic                 mem_req_ready,
  input  logic                 mem_rsp_valid,
  input  adma_pkg::word_t      mem_rsp_data,
  output adma_pkg::word_t      card_tx_data,
  output logic                 card_tx_valid,
  input  logic                 card_tx_ready,
  input  adma_pkg::word_t      card_rx_data,
  input  logic                 card_rx_valid,
  output logic                 card_rx_ready
);
  import adma_pkg::*;

  // Per-word phases
  typedef enum logic [1:0] {
    mv_idle,
    mv_req,
    mv_rsp,
    mv_card
  } mv_state_t;

  mv_state_t state;
  logic      dir_tx;
  addr_t     addr;
  addr_t     next_addr;
  len_t      remaining;
  logic      last_word;
  logic      word_done;

  assign next_addr = addr + addr_t'(`ADMA_WORD_BYTES);
  assign last_word = (remaining == len_t'(1));

  // Read path ends on the card, write path ends on memory
  assign word_done = (state == mv_req && !dir_tx && mem_req_ready) ||
                     (state == mv_card && dir_tx && card_tx_ready);

  always_ff @(posedge clock) begin
    if (!reset) begin
      state         <= mv_idle;
      dir_tx        <= 1'b0;
      move_done     <= 1'b0;
      mem_req_valid <= 1'b0;
      card_tx_valid <= 1'b0;
      card_rx_ready <= 1'b0;
    end else begin
      move_done <= 1'b0;

      case (state)
        mv_idle: begin
          if (move_start) begin
            dir_tx    <= to_card;
            addr      <= move_desc.address;
            remaining <= move_desc.length;
            if (move_desc.length == '0) begin
              move_done <= 1'b1;
            end else if (to_card) begin
              state         <= mv_req;
              mem_req_valid <= 1'b1;
              mem_req       <= '{addr: move_desc.address, write: 1'b0, wdata: '0};
            end else begin
              state         <= mv_card;
              card_rx_ready <= 1'b1;
            end
          end
        end

        mv_req: begin
          if (mem_req_ready) begin
            mem_req_valid <= 1'b0;
            if (dir_tx) begin
              state <= mv_rsp;
            end
          end
        end

        mv_rsp: begin
          if (mem_rsp_valid) begin
            card_tx_data  <= mem_rsp_data;
            card_tx_valid <= 1'b1;
            state         <= mv_card;
          end
        end

        mv_card: begin
          if (dir_tx) begin
            if (card_tx_ready) begin
              card_tx_valid <= 1'b0;
            end
          end else if (card_rx_valid) begin
            card_rx_ready <= 1'b0;
            mem_req_valid <= 1'b1;
            mem_req       <= '{addr: addr, write: 1'b1, wdata: card_rx_data};
            state         <= mv_req;
          end
        end

        default: state <= mv_idle;
      endcase

      // Step to the next word or finish
      if (word_done) begin
        addr      <= next_addr;
        remaining <= remaining - len_t'(1);
        if (last_word) begin
          state     <= mv_idle;
          move_done <= 1'b1;
        end else if (dir_tx) begin
          state         <= mv_req;
          mem_req_valid <= 1'b1;
          mem_req       <= '{addr: next_addr, write: 1'b0, wdata: '0};
        end else begin
          state         <= mv_card;
          card_rx_ready <= 1'b1;
        end
      end
    end
  end

endmodule

/* logic/adma_mem_arbiter.sv */
`timescale 1ns/1ps

module adma_mem_arbiter (
  input  logic               clock,
  input  logic               reset,
  input  adma_pkg::mem_req_t desc_req,
  input  logic               desc_req_valid,
  output logic               desc_req_ready,
  output logic               desc_rsp_valid,
  output adma_pkg::word_t    desc_rsp_data,
  input  adma_pkg::mem_req_t data_req,
  input  logic               data_req_valid,
  output logic               data_req_ready,
  output logic               data_rsp_valid,
  output adma_pkg::word_t    data_rsp_data,
  output adma_pkg::mem_req_t mem_req,
  output logic               mem_req_valid,
  input  logic               mem_req_ready,
  input  logic               mem_rsp_valid,
  input  adma_pkg::word_t    mem_rsp_data
);

  // Owner encoding: 0 is the fetcher, 1 the mover
  logic locked;
  logic owner_data;
  logic last_data;
  logic wait_rsp;
  logic pick_data;
  logic sel_data;
  logic take;

  // Round-robin favors the peer that did not go last
  always_comb begin
    if (desc_req_valid && data_req_valid) begin
      pick_data = !last_data;
    end else begin
      pick_data = data_req_valid;
    end
  end

  assign sel_data = locked ? owner_data : pick_data;

  ////////////////////////////////////////////////////////////
  // Request mux and response routing
  ////////////////////////////////////////////////////////////

  assign mem_req        = sel_data ? data_req : desc_req;
  assign mem_req_valid  = !wait_rsp && (sel_data ? data_req_valid : desc_req_valid);
  assign desc_req_ready = !wait_rsp && !sel_data && mem_req_ready;
  assign data_req_ready = !wait_rsp && sel_data && mem_req_ready;
  assign take           = mem_req_valid && mem_req_ready;

  assign desc_rsp_valid = wait_rsp && !owner_data && mem_rsp_valid;
  assign data_rsp_valid = wait_rsp && owner_data && mem_rsp_valid;
  assign desc_rsp_data  = mem_rsp_data;
  assign data_rsp_data  = mem_rsp_data;

  always_ff @(posedge clock) begin
    if (!reset) begin
      locked     <= 1'b0;
      owner_data <= 1'b0;
      last_data  <= 1'b1;
      wait_rsp   <= 1'b0;
    end else begin
      // Lock on first presentation so the request holds steady
      if (!locked && (desc_req_valid || data_req_valid)) begin
        locked     <= 1'b1;
        owner_data <= pick_data;
      end
      if (take) begin
        if (mem_req.write) begin
          locked    <= 1'b0;
          last_data <= sel_data;
        end else begin
          wait_rsp <= 1'b1;
        end
      end
      if (wait_rsp && mem_rsp_valid) begin
        wait_rsp  <= 1'b0;
        locked    <= 1'b0;
        last_data <= owner_data;
      end
    end
  end

endmodule

/* logic/adma_engine.sv */
`timescale 1ns/1ps

module adma_engine (
  input  logic               clock,
  input  logic               reset,
  input  logic               start,
  input  adma_pkg::addr_t    table_addr,
  input  logic               to_card,
  input  logic               irq_clear,
  output adma_pkg::dma_irq_t irq,
  output logic               busy,
  output adma_pkg::mem_req_t mem_req,
  output logic               mem_req_valid,
  input  logic               mem_req_ready,
  input  logic               mem_rsp_valid,
  input  adma_pkg::word_t    mem_rsp_data,
  output adma_pkg::word_t    card_tx_data,
  output logic               card_tx_valid,
  input  logic               card_tx_ready,
  input  adma_pkg::word_t    card_rx_data,
  input  logic               card_rx_valid,
  output logic               card_rx_ready
);
  import adma_pkg::*;

  // Sequencer and fetcher
  logic       fetch_start;
  logic       prefetch_start;
  addr_t      fetch_addr;
  logic       fetch_done;
  adma_desc_t fetch_desc;

  // Sequencer and mover
  logic       move_start;
  adma_desc_t move_desc;
  logic       move_done;

  // Peer memory ports
  mem_req_t desc_req;
  logic     desc_req_valid;
  logic     desc_req_ready;
  logic     desc_rsp_valid;
  word_t    desc_rsp_data;
  mem_req_t data_req;
  logic     data_req_valid;
  logic     data_req_ready;
  logic     data_rsp_valid;
  word_t    data_rsp_data;

  adma_sequencer sequencer_i (
    .clock          (clock),
    .reset          (reset),
    .start          (start),
    .table_addr     (table_addr),
    .irq_clear      (irq_clear),
    .irq            (irq),
    .busy           (busy),
    .fetch_start    (fetch_start),
    .prefetch_start (prefetch_start),
    .fetch_addr     (fetch_addr),
    .fetch_done     (fetch_done),
    .fetch_desc     (fetch_desc),
    .move_start     (move_start),
    .move_desc      (move_desc),
    .move_done      (move_done)
  );

  adma_desc_fetch desc_fetch_i (
    .clock          (clock),
    .reset          (reset),
    .fetch_start    (fetch_start),
    .prefetch_start (prefetch_start),
    .fetch_addr     (fetch_addr),
    .fetch_done     (fetch_done),
    .fetch_desc     (fetch_desc),
    .mem_req        (desc_req),
    .mem_req_valid  (desc_req_valid),
    .mem_req_ready  (desc_req_ready),
    .mem_rsp_valid  (desc_rsp_valid),
    .mem_rsp_data   (desc_rsp_data)
  );

  adma_data_mover data_mover_i (
    .clock          (clock),
    .reset          (reset),
    .to_card        (to_card),
    .move_start     (move_start),
    .move_desc      (move_desc),
    .move_done      (move_done),
    .mem_req        (data_req),
    .mem_req_valid  (data_req_valid),
    .mem_req_ready  (data_req_ready),
    .mem_rsp_valid  (data_rsp_valid),
    .mem_rsp_data   (data_rsp_data),
    .card_tx_data   (card_tx_data),
    .card_tx_valid  (card_tx_valid),
    .card_tx_ready  (card_tx_ready),
    .card_rx_data   (card_rx_data),
    .card_rx_valid  (card_rx_valid),
    .card_rx_ready  (card_rx_ready)
  );

  adma_mem_arbiter mem_arbiter_i (
    .clock          (clock),
    .reset          (reset),
    .desc_req       (desc_req),
    .desc_req_valid (desc_req_valid),
    .desc_req_ready (desc_req_ready),
    .desc_rsp_valid (desc_rsp_valid),
    .desc_rsp_data  (desc_rsp_data),
    .data_req       (data_req),
    .data_req_valid (data_req_valid),
    .data_req_ready (data_req_ready),
    .data_rsp_valid (data_rsp_valid),
    .data_rsp_data  (data_rsp_data),
    .mem_req        (mem_req),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_rsp_valid  (mem_rsp_valid),
    .mem_rsp_data   (mem_rsp_data)
  );

endmodule

/* tb/adma_engine_assert.sv */
`timescale 1ns/1ps

module adma_engine_assert (
  input logic               clock,
  input logic               reset,
  input adma_pkg::dma_irq_t irq,
  input logic               irq_clear,
  input logic               busy,
  input adma_pkg::mem_req_t mem_req,
  input logic               mem_req_valid,
  input logic               mem_req_ready,
  input adma_pkg::word_t    card_tx_data,
  input logic               card_tx_valid,
  input logic               card_tx_ready
);

  int failures = 0;

  ////////////////////////////////////////////////////////////
  // Handshake stability
  ////////////////////////////////////////////////////////////

  mem_req_hold: assert property (@(posedge clock) disable iff (!reset)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
  else begin
    failures++;
    $error("mem_req changed or was withdrawn while stalled");
  end

  card_tx_hold: assert property (@(posedge clock) disable iff (!reset)
    card_tx_valid && !card_tx_ready |=> card_tx_valid && $stable(card_tx_data))
  else begin
    failures++;
    $error("card_tx_data changed or was withdrawn while stalled");
  end

  ////////////////////////////////////////////////////////////
  // Interrupt flags and idle port
  ////////////////////////////////////////////////////////////

  done_sticky: assert property (@(posedge clock) disable iff (!reset)
    irq.xfer_done && !irq_clear |=> irq.xfer_done)
  else begin
    failures++;
    $error("xfer_done fell without irq_clear");
  end

  error_sticky: assert property (@(posedge clock) disable iff (!reset)
    irq.adma_error && !irq_clear |=> irq.adma_error)
  else begin
    failures++;
    $error("adma_error fell without irq_clear");
  end

  // No memory traffic once the walk has stopped
  idle_quiet: assert property (@(posedge clock) disable iff (!reset)
    !busy |-> !mem_req_valid)
  else begin
    failures++;
    $error("memory request while the engine is idle");
  end

endmodule

/* tb/adma_engine_tb.sv */
`timescale 1ns/1ps

module adma_engine_tb;
  import adma_pkg::*;

  localparam int MEM_BYTES   = 4096;
  localparam int IRQ_TIMEOUT = 2000;
  localparam int WATCHDOG    = 20000;

  // Action codes of the attribute word
  localparam logic [1:0] code_nop  = 2'b00;
  localparam logic [1:0] code_tran = 2'b10;
  localparam logic [1:0] code_link = 2'b11;

  logic     clock, reset, start, to_card, irq_clear, busy;
  addr_t    table_addr;
  dma_irq_t irq;
  mem_req_t mem_req;
  logic     mem_req_valid, mem_req_ready, mem_rsp_valid;
  word_t    mem_rsp_data;
  word_t    card_tx_data, card_rx_data;
  logic     card_tx_valid, card_tx_ready, card_rx_valid, card_rx_ready;

  word_t       mem [0:1023];
  word_t       tx_q[$];
  word_t       rx_q[$];
  logic [31:0] lfsr_state;
  logic [31:0] rbits;
  int          errors, timeouts, assert_fails;
  logic        random_mode, rx_enable, rnd, rx_on, rx_taken;
  logic        rd_pending;
  addr_t       rd_addr;
  int          rd_wait;

  adma_engine dut_i (.*);

  bind adma_engine adma_engine_assert assert_i (
    .clock (clock), .reset (reset), .irq (irq), .irq_clear (irq_clear), .busy (busy),
    .mem_req (mem_req), .mem_req_valid (mem_req_valid), .mem_req_ready (mem_req_ready),
    .card_tx_data (card_tx_data), .card_tx_valid (card_tx_valid),
    .card_tx_ready (card_tx_ready)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits       = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic word_t fill_word(input addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c96e1;
  endfunction

  function automatic word_t read_mem(input addr_t a);
    return mem[a[11:2]];
  endfunction

  function automatic void write_mem(input addr_t a, input word_t w);
    mem[a[11:2]] = w;
  endfunction

  // Low word: length 31:16, action 5:4, end 1, valid 0
  task automatic put_desc(input addr_t at, input logic valid, input logic last,
                          input logic [1:0] act, input logic [15:0] len, input addr_t target);
    write_mem(at, {len, 10'd0, act, 2'b00, last, valid});
    write_mem(at + 32'd4, target);
  endtask

  task automatic expect_equal(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected)
    else begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", test, expected, actual);
    end
  endtask

  task automatic expect_region(input string test, input int first, input addr_t base,
                               input int count);
    for (int i = 0; i < count; i++) begin
      if (first + i < tx_q.size()) begin
        expect_equal(test, fill_word(base + addr_t'(4 * i)), tx_q[first + i]);
      end
    end
  endtask

  task automatic clear_irq();
    irq_clear = 1'b1;
    @(posedge clock);
    #1;
    irq_clear = 1'b0;
  endtask

  task automatic start_walk(input string test, input addr_t base, input logic dir_tx);
    tx_q.delete();
    rx_q.delete();
    table_addr = base;
    to_card    = dir_tx;
    start      = 1'b1;
    @(posedge clock);
    #1;
    start = 1'b0;
    // Walk leaves idle on the edge that takes start
    expect_equal(test, 32'd1, 32'(busy));
  endtask

  // mask bit 1 is xfer_done, bit 0 is adma_error
  task automatic wait_irq(input string test, input logic [1:0] mask);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < IRQ_TIMEOUT) begin
      @(posedge clock);
      seen = (irq.xfer_done && mask[1]) || (irq.adma_error && mask[0]);
      cycles++;
    end
    #1;
    if (!seen) begin
      timeouts++;
      $display("%s: no interrupt within %0d cycles", test, IRQ_TIMEOUT);
    end else begin
      expect_equal(test, 32'd0, 32'(busy));
    end
  endtask

  task automatic run_two_tran(input string test);
    clear_irq();
    start_walk(test, 32'h100, 1'b1);
    wait_irq(test, 2'b11);
    expect_equal(test, 32'd1, 32'(irq.xfer_done));
    expect_equal(test, 32'd0, 32'(irq.adma_error));
    expect_equal(test, 32'd7, tx_q.size());
    expect_region(test, 0, 32'h400, 4);
    expect_region(test, 4, 32'h600, 3);
  endtask

  ////////////////////////////////////////////////////////////
  // Memory and card models
  ////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    rnd      = random_mode;
    rx_on    = rx_enable;
    rx_taken = card_rx_valid && card_rx_ready;
    if (mem_req_valid && mem_req_ready) begin
      if (mem_req.addr >= MEM_BYTES) begin
        errors++;
        $display("Memory access outside the model at %h", mem_req.addr);
      end
      if (mem_req.write) begin
        write_mem(mem_req.addr, mem_req.wdata);
      end else begin
        rd_pending = 1'b1;
        rd_addr    = mem_req.addr;
        rd_wait    = rnd ? int'(take_bits(2)) : 0;
      end
    end
    if (card_tx_valid && card_tx_ready) tx_q.push_back(card_tx_data);
    if (rx_taken) rx_q.push_back(card_rx_data);
    #1;
    mem_rsp_valid = 1'b0;
    if (rd_pending) begin
      if (rd_wait == 0) begin
        mem_rsp_valid = 1'b1;
        mem_rsp_data  = read_mem(rd_addr);
        rd_pending    = 1'b0;
      end else begin
        rd_wait--;
      end
    end
    // Ready three cycles in four under random stalls
    rbits         = rnd ? take_bits(2) : 32'd1;
    mem_req_ready = (rbits != 32'd0);
    rbits         = rnd ? take_bits(1) : 32'd1;
    card_tx_ready = rbits[0];
    if (!rx_on) begin
      card_rx_valid = 1'b0;
    end else if (!card_rx_valid || rx_taken) begin
      card_rx_valid = 1'b1;
      card_rx_data  = take_bits(32);
    end
  end

  initial begin
    repeat (WATCHDOG) @(posedge clock);
    $display("Run did not finish within %0d cycles", WATCHDOG);
    $display("Test failures found");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Scenarios
  ////////////////////////////////////////////////////////////

  initial begin
    reset = 1'b0;
    start = 1'b0;
    table_addr = '0;
    to_card = 1'b0;
    irq_clear = 1'b0;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_data = '0;
    card_tx_ready = 1'b0;
    card_rx_valid = 1'b0;
    card_rx_data = '0;
    lfsr_state = 32'h38638276;
    errors = 0;
    timeouts = 0;
    random_mode = 1'b0;
    rx_enable = 1'b0;
    rd_pending = 1'b0;
    rd_addr = '0;
    rd_wait = 0;
    for (int i = 0; i < MEM_BYTES / 4; i++) begin
      write_mem(addr_t'(i * 4), fill_word(addr_t'(i * 4)));
    end
    put_desc(32'h100, 1'b1, 1'b0, code_tran, 16'd4, 32'h400);
    put_desc(32'h108, 1'b1, 1'b1, code_tran, 16'd3, 32'h600);
    put_desc(32'h180, 1'b1, 1'b1, code_tran, 16'd5, 32'h800);
    // Line after the link is invalid, so a missed link shows as an error
    put_desc(32'h200, 1'b1, 1'b0, code_link, 16'd0, 32'h300);
    put_desc(32'h208, 1'b0, 1'b0, code_nop, 16'd0, 32'h0);
    put_desc(32'h300, 1'b1, 1'b1, code_nop, 16'd0, 32'h0);
    put_desc(32'h280, 1'b0, 1'b0, code_tran, 16'd4, 32'h400);
    put_desc(32'h380, 1'b1, 1'b1, code_nop, 16'd0, 32'h0);
    put_desc(32'h3c0, 1'b1, 1'b1, code_tran, 16'd2, 32'ha00);

    repeat (16) @(posedge clock);
    #1;
    reset = 1'b1;
    repeat (2) @(posedge clock);
    #1;

    // Outputs idle out of reset
    expect_equal("reset_state", 32'd0,
                 32'({mem_req_valid, card_tx_valid, card_rx_ready, busy, irq}));

    run_two_tran("tx_two_tran");

    clear_irq();
    rx_enable = 1'b1;
    start_walk("rx_one_tran", 32'h180, 1'b0);
    wait_irq("rx_one_tran", 2'b11);
    rx_enable = 1'b0;
    expect_equal("rx_one_tran", 32'd0, 32'(irq.adma_error));
    expect_equal("rx_one_tran", 32'd5, rx_q.size());
    for (int i = 0; i < 5 && i < rx_q.size(); i++) begin
      expect_equal("rx_one_tran", rx_q[i], read_mem(32'h800 + addr_t'(4 * i)));
    end

    clear_irq();
    start_walk("link_nop_end", 32'h200, 1'b1);
    wait_irq("link_nop_end", 2'b11);
    expect_equal("link_nop_end", 32'd1, 32'(irq.xfer_done));
    expect_equal("link_nop_end", 32'd0, 32'(irq.adma_error));
    expect_equal("link_nop_end", 32'd0, tx_q.size() + rx_q.size());

    clear_irq();
    rx_enable = 1'b1;
    start_walk("invalid_desc", 32'h280, 1'b0);
    wait_irq("invalid_desc", 2'b11);
    repeat (8) @(posedge clock);
    #1;
    rx_enable = 1'b0;
    expect_equal("invalid_desc", 32'd1, 32'(irq.adma_error));
    expect_equal("invalid_desc", 32'd0, 32'(irq.xfer_done));
    expect_equal("invalid_desc", 32'd0, tx_q.size() + rx_q.size());

    random_mode = 1'b1;
    run_two_tran("tx_random_stall");
    random_mode = 1'b0;

    // Set both flags, clear them, then walk again
    clear_irq();
    start_walk("irq_clear_restart", 32'h280, 1'b1);
    wait_irq("irq_clear_restart", 2'b01);
    start_walk("irq_clear_restart", 32'h380, 1'b1);
    wait_irq("irq_clear_restart", 2'b10);
    expect_equal("irq_clear_restart", 32'd3, 32'(irq));
    clear_irq();
    expect_equal("irq_clear_restart", 32'd0, 32'(irq));
    start_walk("irq_clear_restart", 32'h3c0, 1'b1);
    wait_irq("irq_clear_restart", 2'b11);
    expect_equal("irq_clear_restart", 32'd2, 32'(irq));
    expect_equal("irq_clear_restart", 32'd2, tx_q.size());
    expect_region("irq_clear_restart", 0, 32'ha00, 2);

    repeat (4) @(posedge clock);
    assert_fails = dut_i.assert_i.failures;
    $display("Check errors: %0d, timeouts: %0d, assertion failures: %0d",
             errors, timeouts, assert_fails);
    if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* adma_engine.f */
+incdir+logic
logic/adma_pkg.sv
logic/adma_sequencer.sv
logic/adma_desc_fetch.sv
logic/adma_data_mover.sv
logic/adma_mem_arbiter.sv
logic/adma_engine.sv
tb/adma_engine_assert.sv
tb/adma_engine_tb.sv

/* Makefile */
SIM       = verilator
TOP       = adma_engine_tb
FILELIST  = adma_engine.f
FLAGS     = --binary --timing --assert --top-module $(TOP)
RUN_FLAGS = +verilator+error+limit+100
PASS_TEXT = All tests passed!
EXE       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

# Exit status comes from the search for the pass line
run: compile
	@out="$$($(EXE) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir
